// ==== src/audio_const_pkg.sv ====
// Audio stage constants
`default_nettype none

package audio_const_pkg;

	// --------------------
	// Sample format
	// --------------------

	// Width of one signed channel sample
	localparam int sample_w = 16;

	// Largest positive sample value
	localparam int sample_max = 2 ** (sample_w - 1) - 1;

	// Speaker step is 2048 shifted left by the 2-bit volume
	localparam int spk_base_shift = 11;

	// --------------------
	// Compressor curves
	// --------------------

	// Linear gain below the knee, divisor above it
	localparam logic [sample_w-1:0] comp_gain_2x = sample_w'(2);
	localparam logic [sample_w-1:0] comp_div_2x  = sample_w'(4);
	localparam logic [sample_w-1:0] comp_gain_4x = sample_w'(4);
	localparam logic [sample_w-1:0] comp_div_4x  = sample_w'(8);

	// Knee placed so both segments meet near full scale
	localparam logic [sample_w-1:0] comp_knee_2x =
		sample_w'((sample_max * (comp_div_2x - 1)) / (comp_div_2x * comp_gain_2x - 1) + 1);
	localparam logic [sample_w-1:0] comp_knee_4x =
		sample_w'((sample_max * (comp_div_4x - 1)) / (comp_div_4x * comp_gain_4x - 1) + 1);

	// Offset of the upper segment, equal to the linear value at the knee
	localparam logic [sample_w-1:0] comp_base_2x = sample_w'(comp_knee_2x * comp_gain_2x);
	localparam logic [sample_w-1:0] comp_base_4x = sample_w'(comp_knee_4x * comp_gain_4x);

	// Largest input that both curves map without wrapping, 4x is the tighter one
	localparam int comp_safe_max =
		comp_knee_4x + comp_div_4x * (sample_max - comp_base_4x) + comp_div_4x - 1;

endpackage

`default_nettype wire

// ==== src/audio_types_pkg.sv ====
// Audio stage types
`default_nettype none

package audio_types_pkg;

	// --------------------
	// Control encodings
	// --------------------

	// Output boost select, code 3 is treated as 4x
	typedef enum logic [1:0] {
		boost_none = 2'd0,
		boost_2x   = 2'd1,
		boost_4x   = 2'd2
	} boost_t;

	// --------------------
	// Bundles
	// --------------------

	// One stereo frame, left in the upper half
	typedef struct packed {
		logic signed [audio_const_pkg::sample_w-1:0] left;
		logic signed [audio_const_pkg::sample_w-1:0] right;
	} stereo_sample_t;

	// User audio settings
	typedef struct packed {
		// Speaker loudness, 0 is quietest
		logic [1:0] speaker_vol;
		boost_t     boost;
	} audio_ctrl_t;

endpackage

`default_nettype wire

// ==== src/speaker_mixer.sv ====
// PC speaker mixer
`default_nettype none

module speaker_mixer (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire audio_types_pkg::stereo_sample_t sample_in,
	input  wire                             speaker,
	input  wire [1:0]                       speaker_vol,
	output audio_types_pkg::stereo_sample_t mixed
);

	import audio_const_pkg::*;
	import audio_types_pkg::*;

	// Registered DC step, one stage ahead of the mix
	logic [sample_w-1:0] spk_step;
	logic [sample_w-1:0] step_next;
	stereo_sample_t      mix_next;

	// --------------------
	// Speaker step
	// --------------------

	// Step sizes are 2048, 4096, 8192 and 16384
	always_comb begin
		if (speaker) begin
			step_next = (sample_w'(1) << spk_base_shift) << speaker_vol;
		end else begin
			step_next = '0;
		end
	end

	// --------------------
	// Channel mix
	// --------------------

	// Sum wraps at the sample width, no saturation
	always_comb begin
		mix_next.left  = sample_in.left + $signed(spk_step);
		mix_next.right = sample_in.right + $signed(spk_step);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			spk_step <= '0;
			mixed    <= '0;
		end else begin
			spk_step <= step_next;
			mixed    <= mix_next;
		end
	end

	// Once out of reset the mix carries only defined values
	mixed_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$isunknown(mixed)
	) else $error("speaker_mixer: mixed has unknown bits");

endmodule

`default_nettype wire

// ==== src/soft_compressor.sv ====
// Soft audio compressor
`default_nettype none

module soft_compressor (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire audio_types_pkg::stereo_sample_t mixed,
	input  wire audio_types_pkg::boost_t    boost,
	output audio_types_pkg::stereo_sample_t compressed
);

	import audio_const_pkg::*;
	import audio_types_pkg::*;

	stereo_sample_t comp_next;

	// --------------------
	// Curve
	// --------------------

	// Two-segment curve on the magnitude, sign put back afterwards
	function automatic logic [sample_w-1:0] compress(
		input logic [sample_w-1:0] s,
		input boost_t              b
	);
		logic [sample_w-1:0] mag;
		logic [sample_w-1:0] curve_2x;
		logic [sample_w-1:0] curve_4x;
		logic [sample_w-1:0] res;

		// -32768 gives 32768 here, which the unsigned math handles
		mag = s[sample_w-1] ? (~s + 1'b1) : s;

		if (mag < comp_knee_2x) begin
			curve_2x = mag * comp_gain_2x;
		end else begin
			curve_2x = ((mag - comp_knee_2x) / comp_div_2x) + comp_base_2x;
		end

		if (mag < comp_knee_4x) begin
			curve_4x = mag * comp_gain_4x;
		end else begin
			curve_4x = ((mag - comp_knee_4x) / comp_div_4x) + comp_base_4x;
		end

		// Unused code 3 falls through to the 4x curve
		case (b)
			boost_2x: res = curve_2x;
			default:  res = curve_4x;
		endcase

		// Results near full scale wrap past the sample width
		return s[sample_w-1] ? (~res + 1'b1) : res;
	endfunction

	// --------------------
	// Output register
	// --------------------

	always_comb begin
		comp_next.left  = compress(mixed.left, boost);
		comp_next.right = compress(mixed.right, boost);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			compressed <= '0;
		end else begin
			compressed <= comp_next;
		end
	end

	// --------------------
	// Checks
	// --------------------

	// Silence stays silent through the curve
	zero_in_zero_out: assert property (
		@(posedge clk_sys) disable iff (reset)
		(mixed == '0) |=> (compressed == '0)
	) else $error("soft_compressor: zero input gave nonzero output");

	// Positive inputs in the non-wrapping range keep their sign
	left_sign_kept: assert property (
		@(posedge clk_sys) disable iff (reset)
		(!mixed.left[sample_w-1] && (int'(mixed.left) <= comp_safe_max))
		|=> !compressed.left[sample_w-1]
	) else $error("soft_compressor: left channel turned negative");

	right_sign_kept: assert property (
		@(posedge clk_sys) disable iff (reset)
		(!mixed.right[sample_w-1] && (int'(mixed.right) <= comp_safe_max))
		|=> !compressed.right[sample_w-1]
	) else $error("soft_compressor: right channel turned negative");

endmodule

`default_nettype wire

// ==== src/audio_out_stage.sv ====
// Audio output stage
`default_nettype none

module audio_out_stage (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire audio_types_pkg::stereo_sample_t sample_in,
	input  wire                             speaker,
	input  wire audio_types_pkg::audio_ctrl_t    ctrl,
	output audio_types_pkg::stereo_sample_t audio_out
);

	import audio_types_pkg::*;

	// Mixer result, also the unboosted output
	stereo_sample_t mixed;
	// Compressor result, one cycle behind mixed
	stereo_sample_t compressed;

	// --------------------
	// Datapath
	// --------------------

	speaker_mixer speaker_mixer_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sample_in   (sample_in),
		.speaker     (speaker),
		.speaker_vol (ctrl.speaker_vol),
		.mixed       (mixed)
	);

	soft_compressor soft_compressor_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mixed      (mixed),
		.boost      (ctrl.boost),
		.compressed (compressed)
	);

	// --------------------
	// Output select
	// --------------------

	// Follows the live boost setting, so latency is 1 or 2 cycles
	always_comb begin
		if (ctrl.boost == boost_none) begin
			audio_out = mixed;
		end else begin
			audio_out = compressed;
		end
	end

endmodule

`default_nettype wire

// ==== verif/audio_checker.sv ====
// Audio output reference checker
`default_nettype none

module audio_checker (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire audio_types_pkg::stereo_sample_t sample_in,
	input  wire                                  speaker,
	input  wire audio_types_pkg::audio_ctrl_t    ctrl,
	input  wire audio_types_pkg::stereo_sample_t audio_out,
	input  wire [2:0]                            phase,
	input  wire                                  done,
	output int                                   error_count,
	output int                                   check_count
);

	timeunit 1ns;
	timeprecision 1ps;

	import audio_const_pkg::*;
	import audio_types_pkg::*;

	// Inputs as sampled at the last rising edge
	logic           prev_reset   = 1'b0;
	stereo_sample_t prev_sample  = '0;
	logic           prev_speaker = 1'b0;
	audio_ctrl_t    prev_ctrl    = '0;

	// Model of the step, mix and compressor registers
	int             model_step  = 0;
	stereo_sample_t model_mixed = '0;
	stereo_sample_t model_comp  = '0;
	logic           model_valid = 1'b0;
	stereo_sample_t expected;

	int checks_done    = 0;
	int mismatch_count = 0;
	int unknown_count  = 0;

	assign error_count = mismatch_count + unknown_count;
	assign check_count = checks_done;

	// --------------------
	// Reference rules
	// --------------------

	function automatic int speaker_step(input logic spk, input logic [1:0] vol);
		if (!spk) begin
			return 0;
		end
		return 1 << (spk_base_shift + int'(vol));
	endfunction

	function automatic logic signed [sample_w-1:0] add_wrap(
		input logic signed [sample_w-1:0] s,
		input int                         step
	);
		return sample_w'(int'(s) + step);
	endfunction

	// Magnitude curve, the sign applied at the end
	function automatic logic signed [sample_w-1:0] expected_curve(
		input logic signed [sample_w-1:0] s,
		input boost_t                     b
	);
		int mag;
		int knee;
		int gain;
		int div;
		int base;
		int res;
		mag = (s < 0) ? -int'(s) : int'(s);
		if (b == boost_2x) begin
			knee = int'(comp_knee_2x);
			gain = int'(comp_gain_2x);
			div  = int'(comp_div_2x);
			base = int'(comp_base_2x);
		end else begin
			knee = int'(comp_knee_4x);
			gain = int'(comp_gain_4x);
			div  = int'(comp_div_4x);
			base = int'(comp_base_4x);
		end
		if (mag < knee) begin
			res = mag * gain;
		end else begin
			res = (mag - knee) / div + base;
		end
		if (s < 0) begin
			res = -res;
		end
		return sample_w'(res);
	endfunction

	function automatic string phase_name(input logic [2:0] p);
		case (p)
			3'd0:    return "reset";
			3'd1:    return "passthrough";
			3'd2:    return "speaker_mix";
			3'd3:    return "boost_2x_curve";
			3'd4:    return "boost_4x_curve";
			3'd5:    return "random_mix";
			default: return "unknown";
		endcase
	endfunction

	// --------------------
	// Compare
	// --------------------

	// Sampled mid-cycle, well away from the edge and the input update
	always @(negedge clk_sys) begin
		if (prev_reset) begin
			model_step  = 0;
			model_mixed = '0;
			model_comp  = '0;
			model_valid = 1'b1;
		end else begin
			// Compressor sees the old mix, the mix sees the old step
			model_comp.left   = expected_curve(model_mixed.left, prev_ctrl.boost);
			model_comp.right  = expected_curve(model_mixed.right, prev_ctrl.boost);
			model_mixed.left  = add_wrap(prev_sample.left, model_step);
			model_mixed.right = add_wrap(prev_sample.right, model_step);
			model_step        = speaker_step(prev_speaker, prev_ctrl.speaker_vol);
		end

		if (model_valid) begin
			expected = (ctrl.boost == boost_none) ? model_mixed : model_comp;
			checks_done++;
			if ($isunknown(audio_out)) begin
				unknown_count++;
				$display("Unknown bits on audio_out during %s at %0t ns",
					phase_name(phase), $time);
			end else if (audio_out !== expected) begin
				mismatch_count++;
				$display("FAILED %s: expected L=%0d R=%0d, actual L=%0d R=%0d at %0t ns",
					phase_name(phase), expected.left, expected.right,
					audio_out.left, audio_out.right, $time);
			end
		end

		prev_reset   = reset;
		prev_sample  = sample_in;
		prev_speaker = speaker;
		prev_ctrl    = ctrl;
	end

	always @(posedge done) begin
		$display("Checks: %0d, mismatches: %0d, unknown outputs: %0d",
			checks_done, mismatch_count, unknown_count);
	end

endmodule

`default_nettype wire

// ==== verif/tb_audio_out_stage.sv ====
// Audio output stage testbench
`default_nettype none

module tb_audio_out_stage;

	timeunit 1ns;
	timeprecision 1ps;

	import audio_types_pkg::*;

	// --------------------
	// Run length
	// --------------------

	localparam int clk_period_ns     = 40;
	localparam int reset_cycles      = 16;
	localparam int idle_cycles       = 4;
	localparam int pass_cycles       = 200;
	localparam int spk_cycles        = 40;
	localparam int curve_rand_cycles = 48;
	localparam int mix_cycles        = 600;
	localparam int drain_cycles      = 4;
	localparam int list_2x_len       = 14;
	localparam int list_4x_len       = 11;

	localparam int total_cycles = reset_cycles + idle_cycles + pass_cycles + 4 * spk_cycles
		+ (2 + list_2x_len + curve_rand_cycles)
		+ 2 * (2 + list_4x_len + curve_rand_cycles)
		+ mix_cycles + drain_cycles;

	localparam int watchdog_cycles = total_cycles + 50;

	// Samples around the 2x and 4x knees, plus the extremes
	logic signed [15:0] list_2x [list_2x_len] = '{
		16'sd0, 16'sd1, -16'sd1, 16'sd7000, 16'sd14043, -16'sd14043, 16'sd14044,
		-16'sd14044, 16'sd14045, 16'sd20000, -16'sd20000, 16'sd32767, -16'sd32767, 16'sh8000
	};
	logic signed [15:0] list_4x [list_4x_len] = '{
		16'sd0, 16'sd3, 16'sd7399, -16'sd7399, 16'sd7400, -16'sd7400, 16'sd7401,
		16'sd16000, -16'sd16000, 16'sd32767, 16'sh8000
	};

	logic           clk_sys = 1'b0;
	logic           reset;
	stereo_sample_t sample_in;
	logic           speaker;
	audio_ctrl_t    ctrl;
	stereo_sample_t audio_out;
	logic [2:0]     phase;
	logic           done;
	int             error_count;
	int             check_count;
	logic [31:0]    seed;

	always #20 clk_sys = ~clk_sys;

	audio_out_stage audio_out_stage_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sample_in (sample_in),
		.speaker   (speaker),
		.ctrl      (ctrl),
		.audio_out (audio_out)
	);

	audio_checker audio_checker_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sample_in   (sample_in),
		.speaker     (speaker),
		.ctrl        (ctrl),
		.audio_out   (audio_out),
		.phase       (phase),
		.done        (done),
		.error_count (error_count),
		.check_count (check_count)
	);

	// --------------------
	// Stimulus helpers
	// --------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic rand_word(output logic [31:0] r);
		seed = lcg_next(seed);
		r = seed;
	endtask

	// Samples from the upper LCG bits, which have the longer period
	task automatic rand_sample(output stereo_sample_t s);
		logic [31:0] r;
		rand_word(r);
		s.left = r[31:16];
		rand_word(r);
		s.right = r[31:16];
	endtask

	task automatic drive(input stereo_sample_t s, input logic spk, input audio_ctrl_t c);
		@(posedge clk_sys);
		#2;
		sample_in = s;
		speaker   = spk;
		ctrl      = c;
	endtask

	// Left channel near the knee with a random sign, right channel anywhere
	task automatic run_curve(input boost_t b, input int knee);
		logic [31:0]    r;
		stereo_sample_t s;
		audio_ctrl_t    c;
		int             mag;
		c.speaker_vol = 2'd0;
		c.boost = b;
		for (int i = 0; i < curve_rand_cycles; i++) begin
			rand_word(r);
			mag = knee + int'(r[23:16]) - 128;
			s.left = r[31] ? 16'(-mag) : 16'(mag);
			rand_word(r);
			s.right = r[31:16];
			drive(s, 1'b0, c);
		end
	endtask

	task automatic run_list_2x();
		stereo_sample_t s;
		audio_ctrl_t    c;
		c.speaker_vol = 2'd0;
		c.boost = boost_2x;
		repeat (2) drive('0, 1'b0, c);
		for (int i = 0; i < list_2x_len; i++) begin
			s.left = list_2x[i];
			s.right = -list_2x[i];
			drive(s, 1'b0, c);
		end
	endtask

	task automatic run_list_4x(input boost_t b);
		stereo_sample_t s;
		audio_ctrl_t    c;
		c.speaker_vol = 2'd0;
		c.boost = b;
		repeat (2) drive('0, 1'b0, c);
		for (int i = 0; i < list_4x_len; i++) begin
			s.left = list_4x[i];
			s.right = -list_4x[i];
			drive(s, 1'b0, c);
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		logic [31:0]    r;
		stereo_sample_t s;
		audio_ctrl_t    c;
		int             hold;
		seed      = 32'h54a797a0;
		reset     = 1'b1;
		sample_in = '0;
		speaker   = 1'b0;
		ctrl      = '0;
		phase     = 3'd0;
		done      = 1'b0;
		hold      = 0;
		c         = '0;

		// Inputs stay random while reset holds the registers at zero
		for (int i = 0; i < reset_cycles; i++) begin
			rand_sample(s);
			rand_word(r);
			c.speaker_vol = r[31:30];
			c.boost = boost_t'(r[29:28]);
			drive(s, r[27], c);
		end
		reset = 1'b0;
		repeat (idle_cycles) drive('0, 1'b0, '0);

		// Plain pass-through
		phase = 3'd1;
		for (int i = 0; i < pass_cycles; i++) begin
			rand_sample(s);
			rand_word(r);
			c.speaker_vol = r[31:30];
			c.boost = boost_none;
			drive(s, 1'b0, c);
		end

		// Speaker step at every volume
		phase = 3'd2;
		for (int v = 0; v < 4; v++) begin
			c.speaker_vol = 2'(v);
			c.boost = boost_none;
			for (int i = 0; i < spk_cycles; i++) begin
				rand_sample(s);
				rand_word(r);
				drive(s, r[31], c);
			end
		end

		phase = 3'd3;
		run_list_2x();
		run_curve(boost_2x, 14044);

		phase = 3'd4;
		run_list_4x(boost_4x);
		run_curve(boost_4x, 7400);
		run_list_4x(boost_t'(2'd3));
		run_curve(boost_t'(2'd3), 7400);

		// Everything random with ctrl held for one to four cycles
		phase = 3'd5;
		for (int i = 0; i < mix_cycles; i++) begin
			if (hold == 0) begin
				rand_word(r);
				c.speaker_vol = r[31:30];
				c.boost = boost_t'(r[29:28]);
				hold = int'(r[27:26]) + 1;
			end
			hold = hold - 1;
			rand_sample(s);
			rand_word(r);
			drive(s, r[31], c);
		end
		repeat (drain_cycles) drive(s, 1'b0, c);

		done = 1'b1;
		#1;
		if (error_count == 0 && check_count > 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_cycles * clk_period_ns);
		$display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== audio_out_stage.f ====
src/audio_const_pkg.sv
src/audio_types_pkg.sv
src/speaker_mixer.sv
src/soft_compressor.sv
src/audio_out_stage.sv
verif/audio_checker.sv
verif/tb_audio_out_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the audio output stage testbench with Verilator and runs it.
# Exit status is 0 only when the run passes.

set -u

cd "$(dirname "$0")" || exit 1

top=tb_audio_out_stage
build_dir=obj_dir
file_list=audio_out_stage.f
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$top" \
	--Mdir "$build_dir" \
	-f "$file_list"
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
sim_status=$?
cat "$log"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test FAILED" "$log"; then
	echo "Failure reported in $log"
	exit 1
fi

if ! grep -q "Test OK" "$log"; then
	echo "No pass line found in $log"
	exit 1
fi

echo "Simulation passed"
exit 0
